//--- axi4s_pkg.sv
`default_nettype none

// stream beat layout shared by ingress, FIFO and egress

package axi4s_pkg;

   // ------------------------------------------------------------
   // beat geometry
   // ------------------------------------------------------------
   localparam int DATA_BYTES = 4;
   localparam int DATA_BITS  = DATA_BYTES * 8;

   typedef logic [DATA_BYTES-1:0] keep_t;   // one bit per data byte

   // ------------------------------------------------------------
   // one beat as stored in the data FIFO
   // ------------------------------------------------------------
   typedef struct packed {
      logic [DATA_BITS-1:0] data;
      keep_t                keep;
      logic                 last;   // forced high on a cut packet
   } beat_t;

endpackage

`default_nettype wire

//--- pkt_pkg.sv
`default_nettype none

// packet level limits and the descriptor format

package pkt_pkg;

   // ------------------------------------------------------------
   // limits and buffer sizes
   // ------------------------------------------------------------
   localparam int MAX_PKT_BEATS   = 16;  // longer packets get cut here
   localparam int DATA_FIFO_DEPTH = 64;  // beats
   localparam int DESC_FIFO_DEPTH = 4;   // descriptors, one per stored packet
   localparam int DROP_CNT_BITS   = 16;

   // beat count, needs to hold MAX_PKT_BEATS itself
   typedef logic [$clog2(MAX_PKT_BEATS+1)-1:0] len_t;

   // ------------------------------------------------------------
   // descriptor written once per stored packet
   // ------------------------------------------------------------
   typedef struct packed {
      len_t len;     // beats stored for this packet
      logic trunc;   // packet was cut at MAX_PKT_BEATS
   } desc_t;

   typedef logic [DROP_CNT_BITS-1:0] drop_cnt_t;   // wraps

endpackage

`default_nettype wire

//--- fifo_if.sv
`default_nettype none

// write and read sides of one fifo_sync instance
interface fifo_if #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
);

   localparam int CNT_W = $clog2(DEPTH + 1);

   // write side
   logic             wr;        // one-cycle strobe, one entry
   T                 wr_data;

   // read side
   logic             rd;        // only while empty is low
   T                 rd_data;   // valid the cycle after rd
   logic             empty;
   logic [CNT_W-1:0] count;     // occupancy, rises the cycle after wr

   // writer looks at count to avoid overflow
   modport wr_side (
      output wr,
      output wr_data,
      input  count
   );

   modport rd_side (
      output rd,
      input  rd_data,
      input  empty
   );

   modport mem (
      input  wr,
      input  wr_data,
      input  rd,
      output rd_data,
      output empty,
      output count
   );

endinterface

`default_nettype wire

//--- fifo_sync.sv
`default_nettype none

// circular buffer with registered read, payload type set by T
module fifo_sync #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  logic axi4s_out,
   input  logic rst_n,
   fifo_if.mem  f
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);   // same as the interface count

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] cnt;

   // wrap at DEPTH-1, so DEPTH need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      logic [PTR_W-1:0] n;
      if (p == PTR_W'(DEPTH - 1))
         n = '0;
      else
         n = p + 1'b1;
      return n;
   endfunction

   // ------------------------------------------------------------
   // storage and registered read
   // ------------------------------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (f.wr)
         mem[wr_ptr] <= f.wr_data;
      if (f.rd)
         f.rd_data <= mem[rd_ptr];   // held until the next rd
   end

   // ------------------------------------------------------------
   // pointers and occupancy
   // ------------------------------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (f.wr)
            wr_ptr <= next_ptr(wr_ptr);
         if (f.rd)
            rd_ptr <= next_ptr(rd_ptr);

         case ({f.wr, f.rd})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;   // both or neither
         endcase
      end
   end

   assign f.count = cnt;
   assign f.empty = (cnt == '0);

endmodule

`default_nettype wire

//--- pkt_ingress_discard.sv
`default_nettype none

// per packet keep / drop / cut decision in front of the two FIFOs
module pkt_ingress_discard (
   input  logic                                axi4s_out,
   input  logic                                rst_n,

   input  logic                                ing_valid,
   input  logic [axi4s_pkg::DATA_BITS-1:0]     ing_data,
   input  axi4s_pkg::keep_t                    ing_keep,
   input  logic                                ing_last,

   fifo_if.wr_side                             data_q,
   fifo_if.wr_side                             desc_q,

   output pkt_pkg::drop_cnt_t                  drop_count
);

   logic          in_pkt;      // inside a packet, next beat is not a start
   logic          storing;     // current packet still going into the FIFO
   pkt_pkg::len_t beat_cnt;    // beats stored so far in this packet
   logic          desc_pend;   // descriptor goes out next cycle
   pkt_pkg::desc_t desc_next;

   logic          sop;
   logic          fits;
   logic          store_beat;
   logic          cut;
   logic          end_beat;
   int            data_used;
   int            desc_used;

   // ------------------------------------------------------------
   // admission test, first beat only
   // ------------------------------------------------------------
   // writes already issued but not yet in count are added here,
   // so the FIFOs can never be overrun
   assign data_used = int'(data_q.count) + int'(data_q.wr);
   assign desc_used = int'(desc_q.count) + int'(desc_q.wr) + int'(desc_pend);

   assign fits = (data_used + pkt_pkg::MAX_PKT_BEATS <= pkt_pkg::DATA_FIFO_DEPTH) &&
                 (desc_used < pkt_pkg::DESC_FIFO_DEPTH);

   assign sop        = !in_pkt;
   assign store_beat = sop ? fits : storing;

   // beat number MAX_PKT_BEATS without last gets cut
   assign cut      = (beat_cnt == pkt_pkg::len_t'(pkt_pkg::MAX_PKT_BEATS - 1)) && !ing_last;
   assign end_beat = ing_last || cut;

   // ------------------------------------------------------------
   // control state and strobes
   // ------------------------------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (!rst_n) begin
         in_pkt     <= 1'b0;
         storing    <= 1'b0;
         beat_cnt   <= '0;
         desc_pend  <= 1'b0;
         data_q.wr  <= 1'b0;
         desc_q.wr  <= 1'b0;
         drop_count <= '0;
      end else begin
         data_q.wr <= 1'b0;
         desc_pend <= 1'b0;
         desc_q.wr <= desc_pend;   // one cycle behind the final beat write

         if (ing_valid) begin
            in_pkt <= !ing_last;

            if (store_beat) begin
               data_q.wr <= 1'b1;
               if (end_beat) begin
                  desc_pend <= 1'b1;
                  beat_cnt  <= '0;
                  storing   <= 1'b0;   // rest of a cut packet is discarded
               end else begin
                  beat_cnt  <= beat_cnt + 1'b1;
                  storing   <= 1'b1;
               end
            end else begin
               storing <= 1'b0;
            end

            if (sop && !fits)
               drop_count <= drop_count + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // payload registers
   // ------------------------------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (ing_valid && store_beat) begin
         data_q.wr_data.data <= ing_data;
         data_q.wr_data.keep <= ing_keep;
         data_q.wr_data.last <= end_beat;   // forced on a cut
      end
      if (ing_valid && store_beat && end_beat) begin
         desc_next.len   <= beat_cnt + 1'b1;
         desc_next.trunc <= cut;
      end
      if (desc_pend)
         desc_q.wr_data <= desc_next;
   end

endmodule

`default_nettype wire

//--- pkt_egress_str_fwd.sv
`default_nettype none

// store-and-forward egress, a descriptor means the packet is fully stored
module pkt_egress_str_fwd (
   input  logic                            axi4s_out,
   input  logic                            rst_n,

   fifo_if.rd_side                         data_q,
   fifo_if.rd_side                         desc_q,

   output logic                            egr_valid,
   output logic [axi4s_pkg::DATA_BITS-1:0] egr_data,
   output axi4s_pkg::keep_t                egr_keep,
   output logic                            egr_last,
   output logic                            egr_trunc
);

   typedef enum logic [1:0] {
      IDLE,
      FETCH,    // descriptor read data arrives
      STREAM    // one beat read per cycle
   } state_t;

   state_t        state;
   pkt_pkg::len_t remaining;
   logic          cur_trunc;   // from the held descriptor

   // ------------------------------------------------------------
   // FIFO read strobes
   // ------------------------------------------------------------
   // wait while the previous last beat is still on the output
   assign desc_q.rd = (state == IDLE) && !desc_q.empty && !egr_valid;
   assign data_q.rd = (state == STREAM);

   // ------------------------------------------------------------
   // FSM and remaining-beat counter
   // ------------------------------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (!rst_n) begin
         state     <= IDLE;
         remaining <= '0;
         egr_valid <= 1'b0;
      end else begin
         egr_valid <= data_q.rd;   // beat shows up one cycle after its read

         case (state)
            IDLE: begin
               if (desc_q.rd)
                  state <= FETCH;
            end
            FETCH: begin
               remaining <= desc_q.rd_data.len;
               state     <= STREAM;
            end
            STREAM: begin
               remaining <= remaining - 1'b1;
               if (remaining == pkt_pkg::len_t'(1))
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge axi4s_out) begin
      if (state == FETCH)
         cur_trunc <= desc_q.rd_data.trunc;
   end

   // ------------------------------------------------------------
   // output beat
   // ------------------------------------------------------------
   assign egr_data  = data_q.rd_data.data;
   assign egr_keep  = data_q.rd_data.keep;
   assign egr_last  = data_q.rd_data.last;
   assign egr_trunc = egr_valid && data_q.rd_data.last && cur_trunc;   // last beat only

endmodule

`default_nettype wire

//--- axi4s_pkt_fifo.sv
`default_nettype none

// packet stream buffer: ingress discard, beat and descriptor FIFOs, egress
module axi4s_pkt_fifo (
   input  logic                            axi4s_out,
   input  logic                            rst_n,

   input  logic                            ing_valid,
   input  logic [axi4s_pkg::DATA_BITS-1:0] ing_data,
   input  axi4s_pkg::keep_t                ing_keep,
   input  logic                            ing_last,

   output logic                            egr_valid,
   output logic [axi4s_pkg::DATA_BITS-1:0] egr_data,
   output axi4s_pkg::keep_t                egr_keep,
   output logic                            egr_last,
   output logic                            egr_trunc,

   output pkt_pkg::drop_cnt_t              drop_count
);

   // ------------------------------------------------------------
   // buffers
   // ------------------------------------------------------------
   fifo_if #(.T(axi4s_pkg::beat_t), .DEPTH(pkt_pkg::DATA_FIFO_DEPTH)) data_q ();
   fifo_if #(.T(pkt_pkg::desc_t),   .DEPTH(pkt_pkg::DESC_FIFO_DEPTH)) desc_q ();

   fifo_sync #(
      .T     (axi4s_pkg::beat_t),
      .DEPTH (pkt_pkg::DATA_FIFO_DEPTH)
   ) u_data_fifo (
      .axi4s_out (axi4s_out),
      .rst_n     (rst_n),
      .f         (data_q.mem)
   );

   fifo_sync #(
      .T     (pkt_pkg::desc_t),
      .DEPTH (pkt_pkg::DESC_FIFO_DEPTH)
   ) u_desc_fifo (
      .axi4s_out (axi4s_out),
      .rst_n     (rst_n),
      .f         (desc_q.mem)
   );

   // ------------------------------------------------------------
   // ingress and egress stages
   // ------------------------------------------------------------
   pkt_ingress_discard u_ingress (
      .axi4s_out  (axi4s_out),
      .rst_n      (rst_n),
      .ing_valid  (ing_valid),
      .ing_data   (ing_data),
      .ing_keep   (ing_keep),
      .ing_last   (ing_last),
      .data_q     (data_q.wr_side),
      .desc_q     (desc_q.wr_side),
      .drop_count (drop_count)
   );

   pkt_egress_str_fwd u_egress (
      .axi4s_out (axi4s_out),
      .rst_n     (rst_n),
      .data_q    (data_q.rd_side),
      .desc_q    (desc_q.rd_side),
      .egr_valid (egr_valid),
      .egr_data  (egr_data),
      .egr_keep  (egr_keep),
      .egr_last  (egr_last),
      .egr_trunc (egr_trunc)
   );

endmodule

`default_nettype wire

//--- tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// packet scoreboard, the head entry is the oldest packet not yet seen
axi4s_pkg::beat_t exp_beats[$];   // stored beats only, last forced on a cut
int               exp_len[$];
logic             exp_trunc[$];
int               exp_id[$];
int               sent_count      = 0;
int               received_count  = 0;
int               skipped_count   = 0;   // sent but never seen, i.e. dropped
int               last_matched_id = -1;

task automatic check_beat(input string name, input axi4s_pkg::beat_t exp,
                          input axi4s_pkg::beat_t act);
   if (act !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act));
endtask

task automatic check_trunc(input string name, input logic exp, input logic act);
   if (act !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act));
endtask

task automatic check_drops(input string name, input pkt_pkg::drop_cnt_t exp,
                           input pkt_pkg::drop_cnt_t act);
   if (act !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act));
endtask

// what the buffer should deliver for one sent packet
task automatic model_packet(input axi4s_pkg::beat_t beats[$], output int id);
   axi4s_pkg::beat_t b;
   int               n;
   n = (beats.size() > pkt_pkg::MAX_PKT_BEATS) ? pkt_pkg::MAX_PKT_BEATS : beats.size();
   for (int i = 0; i < n; i++) begin
      b = beats[i];
      if (i == n - 1)
         b.last = 1'b1;   // cut packets end at beat MAX_PKT_BEATS
      exp_beats.push_back(b);
   end
   exp_len.push_back(n);
   exp_trunc.push_back(beats.size() > pkt_pkg::MAX_PKT_BEATS);
   id = sent_count;
   exp_id.push_back(id);
   sent_count++;
endtask

task automatic retire_head();
   repeat (exp_len[0])
      exp_beats.delete(0);
   last_matched_id = exp_id[0];
   exp_len.delete(0);
   exp_trunc.delete(0);
   exp_id.delete(0);
endtask

// first beat of an output packet, anything sent before it was dropped
task automatic skip_dropped(input logic [axi4s_pkg::DATA_BITS-1:0] first_data);
   while (exp_len.size() > 0 && exp_beats[0].data !== first_data) begin
      retire_head();
      skipped_count++;
   end
   if (exp_len.size() == 0)
      fail_run("an output packet does not match any packet that was sent");
endtask

`endif

//--- tb_axi4s_pkt_fifo.sv
`default_nettype none

module tb_axi4s_pkt_fifo;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          RESET_CYCLES  = 10;
   localparam int          MAX_LEN       = 20;    // sender side, beyond the cut
   localparam int          N_LIGHT       = 20;
   localparam int          LIGHT_GAP_MIN = 40;
   localparam int          N_FLOOD       = 60;
   localparam int          DRAIN_GAP     = 200;   // both FIFOs empty by then
   localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;
   localparam int STIM_CYCLES = RESET_CYCLES + 5 + N_LIGHT * (MAX_LEN * 4 + LIGHT_GAP_MIN + 15)
      + 2 * (MAX_LEN + LIGHT_GAP_MIN) + N_FLOOD * 2 + DRAIN_GAP + 8;
   localparam int WATCHDOG_CYCLES = STIM_CYCLES * 4 + 2000;

   logic                            axi4s_out;
   logic                            rst_n;
   logic                            ing_valid;
   logic [axi4s_pkg::DATA_BITS-1:0] ing_data;
   axi4s_pkg::keep_t                ing_keep;
   logic                            ing_last;
   logic                            egr_valid;
   logic [axi4s_pkg::DATA_BITS-1:0] egr_data;
   axi4s_pkg::keep_t                egr_keep;
   logic                            egr_last;
   logic                            egr_trunc;
   pkt_pkg::drop_cnt_t              drop_count;

   logic [31:0] lfsr;

   axi4s_pkt_fifo DUT (.*);

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   `include "tb_checks.svh"

   // ------------------------------------------------------------
   // random source
   // ------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ LFSR_TAPS;
      return n;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);   // one step per bit
      end
      return v;
   endfunction

   // ------------------------------------------------------------
   // ingress driver
   // ------------------------------------------------------------
   task automatic drive_beat(input axi4s_pkg::beat_t b);
      @(posedge axi4s_out);
      #1;
      ing_valid = 1'b1;
      ing_data  = b.data;
      ing_keep  = b.keep;
      ing_last  = b.last;
   endtask

   task automatic drive_idle(input int n);
      repeat (n) begin
         @(posedge axi4s_out);
         #1;
         ing_valid = 1'b0;
         ing_last  = 1'b0;
      end
   endtask

   task automatic send_packet(input int len, input logic inner_gaps, output int id);
      axi4s_pkg::beat_t beats[$];
      axi4s_pkg::beat_t b;
      for (int i = 0; i < len; i++) begin
         b.data = take_bits(axi4s_pkg::DATA_BITS);
         b.keep = axi4s_pkg::keep_t'(take_bits(axi4s_pkg::DATA_BYTES));
         b.last = (i == len - 1);
         beats.push_back(b);
      end
      model_packet(beats, id);
      foreach (beats[i]) begin
         if (inner_gaps && i > 0)
            drive_idle(int'(take_bits(2)));   // 0..3 idle cycles inside the packet
         drive_beat(beats[i]);
      end
   endtask

   task automatic check_quiet(input string when);
      @(negedge axi4s_out);
      if (egr_valid !== 1'b0)
         fail_run({"egr_valid is not low ", when});
      check_drops("drop_count", '0, drop_count);
   endtask

   task automatic wait_for_packet(input int id);
      while (last_matched_id < id)
         @(negedge axi4s_out);
   endtask

   // ------------------------------------------------------------
   // clock, monitor, watchdog
   // ------------------------------------------------------------
   initial begin : clock_gen
      axi4s_out = 1'b0;
      forever #5 axi4s_out = ~axi4s_out;
   end

   initial begin : monitor
      axi4s_pkg::beat_t act;
      int               idx;
      logic             in_out_pkt;
      idx        = 0;
      in_out_pkt = 1'b0;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge axi4s_out);
         if (egr_valid === 1'b1) begin
            act = '{data: egr_data, keep: egr_keep, last: egr_last};
            if (!in_out_pkt) begin
               skip_dropped(egr_data);
               in_out_pkt = 1'b1;
               idx        = 0;
            end
            check_beat("egr beat", exp_beats[idx], act);
            check_trunc("egr_trunc", exp_trunc[0] && exp_beats[idx].last, egr_trunc);
            idx++;
            if (act.last) begin
               retire_head();
               received_count++;
               in_out_pkt = 1'b0;
            end
         end else if (in_out_pkt) begin
            fail_run("egr_valid went low in the middle of an output packet");
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge axi4s_out);
      fail_run("watchdog expired, the output never finished");
   end

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial begin : stimulus
      int id;
      lfsr      = 32'hac62;
      rst_n     = 1'b0;
      ing_valid = 1'b0;
      ing_data  = '0;
      ing_keep  = '0;
      ing_last  = 1'b0;

      repeat (RESET_CYCLES - 1)
         check_quiet("during reset");
      @(posedge axi4s_out);
      #1;
      rst_n = 1'b1;
      repeat (5)
         check_quiet("right after reset");

      // light traffic, inner gaps on, nothing may be dropped
      for (int p = 0; p < N_LIGHT; p++) begin
         send_packet(int'(take_bits(5)) % MAX_LEN + 1, 1'b1, id);
         drive_idle(LIGHT_GAP_MIN + int'(take_bits(4)));
      end
      wait_for_packet(id);
      check_drops("drop_count", '0, drop_count);

      send_packet(MAX_LEN, 1'b0, id);   // gets cut
      drive_idle(LIGHT_GAP_MIN);
      send_packet(5, 1'b0, id);
      drive_idle(LIGHT_GAP_MIN);
      wait_for_packet(id);
      check_drops("drop_count", '0, drop_count);
      if (skipped_count != 0)
         fail_run("a packet was lost under light traffic");

      // back to back short packets, then one marker after the drain
      for (int p = 0; p < N_FLOOD; p++)
         send_packet(int'(take_bits(1)) + 1, 1'b0, id);
      drive_idle(DRAIN_GAP);
      send_packet(4, 1'b0, id);
      drive_idle(4);
      wait_for_packet(id);
      check_drops("drop_count", pkt_pkg::drop_cnt_t'(sent_count - received_count), drop_count);
      if (drop_count == '0)
         fail_run("the flood of short packets caused no drops");

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
axi4s_pkg.sv
pkt_pkg.sv
fifo_if.sv
fifo_sync.sv
pkt_ingress_discard.sv
pkt_egress_str_fwd.sv
axi4s_pkt_fifo.sv
tb_axi4s_pkt_fifo.sv
